/* common/alu68kPkg.sv */
package alu68kPkg;

	typedef logic [15:0] word_t;       // ALU data word
	typedef logic [15:0] opcode_t;     // IRD
	typedef logic [15:0] aluRow_t;     // One-hot row, bit n is row n
	typedef logic [2:0]  aluColumn_t;  // Microcode column, 0 = idle
	typedef logic [4:0]  ccr_t;        // X N Z V C
	typedef logic [4:0]  ccrMask_t;    // 1 = take new flag

	// Flag positions inside ccr_t
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	typedef enum logic [4:0] {
		opNone,
		opAnd,
		opOr,
		opEor,
		opExt,    // Byte to word sign extension
		opAdd,
		opAddc,   // Carry in from C
		opAddx,   // Carry in from X
		opSub,
		opSubc,
		opSubx,
		opSub0,   // 0 - op - 1, used by NOT
		opAsl,
		opAsr,
		opLsl,
		opLsr,
		opRol,
		opRor,
		opRoxl,
		opRoxr
	} aluOp_e;

	// Command from the sequencer
	typedef struct packed {
		opcode_t    ird;
		aluColumn_t column;
		word_t      aOperand;
		word_t      dOperand;
		logic       isByte;
		logic       init;
		logic       finish;
	} aluReq_t;

	// Decode stage register contents
	typedef struct packed {
		aluOp_e     op;
		ccrMask_t   mask;
		aluRow_t    row;
		aluColumn_t column;
		word_t      aOperand;
		word_t      dOperand;
		logic       isByte;
		logic       isArX;     // Z only cleared
		logic       noCcrEn;   // Address register destination
		logic       commit;    // init or finish
		logic       finish;
	} decodedCmd_t;

	typedef struct packed {
		word_t result;
		ccr_t  ccr;
	} aluResp_t;

endpackage

/* decode/rowDecoder.sv */
module rowDecoder (
	input  alu68kPkg::opcode_t ird,
	output alu68kPkg::aluRow_t row,
	output logic               noCcrEn,
	output logic               isArX
);
	import alu68kPkg::*;

	logic       eaRdir;   // Data or address register direct
	logic       eaAdir;   // Address register direct
	logic       size11;
	logic [1:0] shiftType;

	assign eaRdir = (ird[5:4] == 2'b00);
	assign eaAdir = (ird[5:3] == 3'b001);
	assign size11 = ird[7] & ird[6];

	// Memory shifts carry the type in 10:9, register shifts in 4:3
	assign shiftType = size11 ? ird[10:9] : ird[4:3];

	function automatic aluRow_t oneRow(input int unsigned n);
		return aluRow_t'(1) << n;
	endfunction

	always_comb begin
		row = '0;   // Mul, div, branches and unlisted groups
		case (ird[15:12])
			4'h0: begin
				if (ird[8])
					row = ird[7] ? oneRow(14) : oneRow(13);   // Dynamic bit ops
				else begin
					case (ird[11:9])
						3'b000: row = oneRow(14);   // ORI
						3'b001: row = oneRow(4);    // ANDI
						3'b010: row = oneRow(5);    // SUBI
						3'b011: row = oneRow(2);    // ADDI
						3'b100: row = ird[7] ? oneRow(14) : oneRow(13);   // Static bit ops
						3'b101: row = oneRow(13);   // EORI
						3'b110: row = oneRow(6);    // CMPI
						default: row = '0;
					endcase
				end
			end
			4'h1, 4'h2, 4'h3: row = oneRow(2);   // MOVE
			4'h4: begin
				if (ird[8])
					row = oneRow(6);   // CHK, LEA
				else begin
					case (ird[11:9])
						3'b000: row = oneRow(10);   // NEGX
						3'b001: row = oneRow(4);    // CLR
						3'b010: row = oneRow(5);    // NEG
						3'b011: row = oneRow(11);   // NOT
						3'b100: row = ird[7] ? oneRow(8) : oneRow(9);   // EXT, SWAP, NBCD
						3'b101: row = oneRow(15);   // TST, TAS
						default: row = '0;
					endcase
				end
			end
			4'h5: begin
				if (size11)
					row = oneRow(15);                       // Scc, DBcc
				else
					row = ird[8] ? oneRow(5) : oneRow(2);   // SUBQ / ADDQ
			end
			4'h7: row = oneRow(2);   // MOVEQ
			4'h8: begin
				if (!size11)
					row = (ird[8] & eaRdir) ? oneRow(9) : oneRow(14);   // SBCD / OR
			end
			4'h9: row = (ird[8] & ~size11 & eaRdir) ? oneRow(10) : oneRow(5);   // SUBX / SUB
			4'hb: row = (ird[8] & ~size11 & ~eaAdir) ? oneRow(13) : oneRow(6);  // EOR / CMP
			4'hc: begin
				if (!size11)
					row = (ird[8] & eaRdir) ? oneRow(3) : oneRow(4);    // ABCD / AND
			end
			4'hd: row = (ird[8] & ~size11 & eaRdir) ? oneRow(12) : oneRow(2);   // ADDX / ADD
			4'he: begin
				case ({shiftType, ird[8]})
					3'd0: row = oneRow(2);    // ASR
					3'd1: row = oneRow(3);    // ASL
					3'd2: row = oneRow(5);    // LSR
					3'd3: row = oneRow(4);    // LSL
					3'd4: row = oneRow(8);    // ROXR
					3'd5: row = oneRow(11);   // ROXL
					3'd6: row = oneRow(10);   // ROR
					default: row = oneRow(9); // ROL
				endcase
			end
			default: row = '0;
		endcase
	end

	// Only NEGX, SUBX and ADDX land in rows 10 and 12 from these groups
	assign isArX = ((ird[15:12] == 4'h4) | (ird[15:12] == 4'h9) | (ird[15:12] == 4'hd))
		& (row[10] | row[12]);

	assign noCcrEn = (ird[15] & ~ird[13] & ird[12] & size11)            // ADDA, SUBA
		| ((ird[15:12] == 4'h5) & eaAdir)                               // ADDQ, SUBQ to An
		| ((~ird[15] & ~ird[14] & ird[13]) & (ird[8:6] == 3'b001));     // MOVEA

endmodule

/* decode/ccrMaskTable.sv */
module ccrMaskTable (
	input  alu68kPkg::aluColumn_t column,
	input  alu68kPkg::aluRow_t    row,
	input  logic                  finish,
	output alu68kPkg::ccrMask_t   mask
);
	import alu68kPkg::*;

	localparam ccrMask_t maskAll  = 5'b11111;
	localparam ccrMask_t maskNzvc = 5'b01111;   // V, C cleared by the op itself
	localparam ccrMask_t maskZ    = 5'b00100;
	localparam ccrMask_t maskKeep = 5'b00000;

	always_comb begin
		mask = maskKeep;
		case (column)
			3'd1: begin
				// AND column, Z only while a bit op is still running
				if (finish)
					mask = maskNzvc;
				else
					mask = (row[13] | row[14]) ? maskZ : maskNzvc;
			end
			3'd2, 3'd3: begin
				case (1'b1)
					row[2], row[3], row[5], row[9], row[10], row[12]: mask = maskAll;
					row[6], row[11]: mask = maskNzvc;   // CMP, NOT
					row[4], row[8], row[13], row[14]: mask = maskNzvc;
					default: mask = maskKeep;           // Row 15 and dropped rows
				endcase
			end
			3'd4: begin
				case (1'b1)
					row[2], row[3], row[4], row[5]: mask = maskAll;   // ASx, LSx
					row[8], row[11]: mask = maskAll;                  // ROXR, ROXL
					row[9], row[10]: mask = maskNzvc;                 // ROL, ROR keep X
					default: mask = maskKeep;
				endcase
			end
			default: mask = maskKeep;   // Columns 0, 5, 6, 7
		endcase
	end

endmodule

/* decode/aluOpSelect.sv */
module aluOpSelect (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  alu68kPkg::aluReq_t    req,
	input  alu68kPkg::aluRow_t    row,
	input  logic                  noCcrEn,
	input  logic                  isArX,
	input  alu68kPkg::ccrMask_t   mask,
	output alu68kPkg::decodedCmd_t cmd
);
	import alu68kPkg::*;

	aluOp_e opNext;

	// Row table only matters for columns 2 to 4
	always_comb begin
		opNext = opNone;
		case (req.column)
			3'd1: opNext = opAnd;
			3'd5: opNext = opExt;
			3'd2, 3'd3, 3'd4: begin
				case (1'b1)
					row[2]: begin
						case (req.column)
							3'd2: opNext = opAdd;
							3'd3: opNext = opAddc;
							default: opNext = opAsr;
						endcase
					end
					row[3]: begin
						case (req.column)
							3'd2: opNext = opAddx;
							3'd3: opNext = opNone;   // ABCD
							default: opNext = opAsl;
						endcase
					end
					row[4]: opNext = (req.column == 3'd4) ? opLsl : opAnd;
					row[5], row[6]: begin
						case (req.column)
							3'd2: opNext = opSub;
							3'd3: opNext = opSubc;
							default: opNext = opLsr;
						endcase
					end
					row[8]: begin
						case (req.column)
							3'd2: opNext = opExt;
							3'd3: opNext = opAnd;
							default: opNext = opRoxr;
						endcase
					end
					row[9]: begin
						if (req.column == 3'd2)
							opNext = opSubx;
						else if (req.column == 3'd4)
							opNext = opRol;   // Column 3 is SBCD
					end
					row[10]: begin
						case (req.column)
							3'd2: opNext = opSubx;
							3'd3: opNext = opSubc;
							default: opNext = opRor;
						endcase
					end
					row[11]: opNext = (req.column == 3'd4) ? opRoxl : opSub0;
					row[12]: opNext = opAddx;
					row[13]: opNext = opEor;
					row[14]: opNext = (req.column == 3'd4) ? opEor : opOr;
					row[15]: opNext = (req.column == 3'd3) ? opAdd : opOr;   // ADD for DBcc
					default: opNext = opNone;   // Rows 1 and 7 are gone
				endcase
			end
			default: opNext = opNone;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cmd <= '0;
		end else if (load) begin
			cmd.op       <= opNext;
			cmd.mask     <= (opNext == opNone) ? ccrMask_t'(0) : mask;   // No op keeps every flag
			cmd.row      <= row;
			cmd.column   <= req.column;
			cmd.aOperand <= req.aOperand;
			cmd.dOperand <= req.dOperand;
			cmd.isByte   <= req.isByte;
			cmd.isArX    <= isArX;
			cmd.noCcrEn  <= noCcrEn;
			cmd.commit   <= req.init | req.finish;
			cmd.finish   <= req.finish;
		end
	end

endmodule

/* execute/aluExecute.sv */
module aluExecute (
	input  alu68kPkg::decodedCmd_t cmd,
	input  alu68kPkg::ccr_t        ccrNow,
	output alu68kPkg::word_t       result,
	output alu68kPkg::ccr_t        flags
);
	import alu68kPkg::*;

	word_t       a;
	word_t       d;
	logic        isAdd;
	logic        addCin;
	logic [8:0]  byteSum;
	logic [16:0] wordSum;
	word_t       addResult;
	logic        addCout;
	logic        addOv;
	logic        resMsb, dMsb, srcMsb;

	logic        shiftRight;
	logic        shiftCin;
	logic        shiftMsb;   // Bit 7 or 15 of the operand
	logic [7:0]  byteShift;
	word_t       wordShift;
	word_t       shiftResult;

	assign a = cmd.aOperand;
	assign d = cmd.dOperand;

	assign isAdd = (cmd.op == opAdd) | (cmd.op == opAddc) | (cmd.op == opAddx);

	always_comb begin
		case (cmd.op)
			opSub0:         addCin = 1'b1;   // NOT = 0 - op - 1
			opAddc, opSubc: addCin = ccrNow[flagC];
			opAddx, opSubx: addCin = ccrNow[flagX];
			default:        addCin = 1'b0;
		endcase
	end

	// D minus A for subtracts
	assign byteSum = isAdd ? ({1'b0, d[7:0]} + {1'b0, a[7:0]} + {8'b0, addCin})
		: ({1'b0, d[7:0]} - {1'b0, a[7:0]} - {8'b0, addCin});
	assign wordSum = isAdd ? ({1'b0, d} + {1'b0, a} + {16'b0, addCin})
		: ({1'b0, d} - {1'b0, a} - {16'b0, addCin});

	assign addResult = cmd.isByte ? {{8{byteSum[7]}}, byteSum[7:0]} : wordSum[15:0];
	assign addCout   = cmd.isByte ? byteSum[8] : wordSum[16];

	assign resMsb = cmd.isByte ? byteSum[7] : wordSum[15];
	assign dMsb   = cmd.isByte ? d[7] : d[15];
	assign srcMsb = isAdd ? (cmd.isByte ? a[7] : a[15]) : ~(cmd.isByte ? a[7] : a[15]);
	assign addOv  = (srcMsb & dMsb & ~resMsb) | (~srcMsb & ~dMsb & resMsb);

	assign shiftMsb   = cmd.isByte ? a[7] : a[15];
	assign shiftRight = (cmd.op == opLsr) | (cmd.op == opAsr) | (cmd.op == opRor)
		| (cmd.op == opRoxr);

	always_comb begin
		case (cmd.op)
			opAsr, opRol:   shiftCin = shiftMsb;
			opRor:          shiftCin = a[0];
			opRoxl, opRoxr: shiftCin = ccrNow[flagX];
			default:        shiftCin = 1'b0;   // LSL, LSR, ASL
		endcase
	end

	assign byteShift = shiftRight ? {shiftCin, a[7:1]} : {a[6:0], shiftCin};
	assign wordShift = shiftRight ? {shiftCin, a[15:1]} : {a[14:0], shiftCin};
	assign shiftResult = cmd.isByte ? {a[15:8], byteShift} : wordShift;   // Upper byte untouched

	always_comb begin
		case (cmd.op)
			opAnd: result = a & d;
			opOr:  result = a | d;
			opEor: result = a ^ d;
			opExt: result = {{8{a[7]}}, a[7:0]};
			opAdd, opAddc, opAddx, opSub, opSubc, opSubx, opSub0: result = addResult;
			opAsl, opAsr, opLsl, opLsr, opRol, opRor, opRoxl, opRoxr: result = shiftResult;
			default: result = '0;
		endcase
	end

	always_comb begin
		flags        = '0;
		flags[flagX] = ccrNow[flagX];   // X held unless the op says otherwise
		flags[flagN] = cmd.isByte ? result[7] : result[15];
		flags[flagZ] = cmd.isByte ? ~(|result[7:0]) : ~(|result);
		case (cmd.op)
			opAnd: begin
				// ROX with zero count, C mirrors X before the loop
				if ((cmd.column == 3'd1) & (cmd.row[11] | cmd.row[8]))
					flags[flagC] = ccrNow[flagX];
			end
			opAdd, opAddc, opAddx, opSub, opSubc, opSubx: begin
				flags[flagC] = addCout;
				flags[flagX] = addCout;
				flags[flagV] = addOv;
			end
			opLsl, opRoxl: begin
				flags[flagC] = shiftMsb;
				flags[flagX] = shiftMsb;
			end
			opLsr, opRoxr, opAsr: begin
				flags[flagC] = a[0];
				flags[flagX] = a[0];
			end
			opAsl: begin
				flags[flagC] = shiftMsb;
				flags[flagX] = shiftMsb;
				// Sticky, set if the MSB changed on any step
				flags[flagV] = ccrNow[flagV] | (shiftMsb ^ (cmd.isByte ? a[6] : a[14]));
			end
			opRol: flags[flagC] = shiftMsb;
			opRor: flags[flagC] = a[0];
			default: ;   // OR, EOR, EXT, SUB0 clear V and C
		endcase
	end

endmodule

/* logic/ccrUnit.sv */
module ccrUnit (
	input  logic                clk,
	input  logic                rst,
	input  logic                update,    // Execute stage done
	input  logic                commit,
	input  logic                finish,
	input  logic                isArX,
	input  logic                noCcrEn,
	input  alu68kPkg::ccrMask_t mask,
	input  alu68kPkg::ccr_t     flags,
	output alu68kPkg::ccr_t     ccr
);
	import alu68kPkg::*;

	ccr_t ccrMasked;

	always_comb begin
		ccrMasked = (flags & mask) | (ccr & ~mask);
		// Multi step ops may clear Z but never set it
		if (finish | isArX)
			ccrMasked[flagZ] = flags[flagZ] & ccr[flagZ];
	end

	always_ff @(posedge clk) begin
		if (rst)
			ccr <= '0;
		else if (update & commit & ~noCcrEn)
			ccr <= ccrMasked;   // An destinations leave flags alone
	end

endmodule

/* logic/alu68k.sv */
module alu68k (
	input  logic               clk,
	input  logic               rst,
	input  logic               cyc,
	input  logic               stb,
	input  alu68kPkg::aluReq_t reqData,
	output logic               ack,
	output alu68kPkg::aluResp_t respData
);
	import alu68kPkg::*;

	aluRow_t     row;
	logic        noCcrEn, isArX;
	ccrMask_t    mask;
	decodedCmd_t cmd;
	word_t       result, resultQ;
	ccr_t        flags, ccr;
	logic        busy;          // Command in flight, until ack
	logic        stageValid;    // Execute cycle
	logic        accept;
	logic        loadCmd;       // First cycle after accept

	assign accept  = cyc & stb & ~busy;
	assign loadCmd = busy & ~stageValid & ~ack;

	rowDecoder rowDecoder_i (.ird(reqData.ird), .row, .noCcrEn, .isArX);

	ccrMaskTable ccrMaskTable_i (.column(reqData.column), .row, .finish(reqData.finish), .mask);

	aluOpSelect aluOpSelect_i (.clk, .rst, .load(loadCmd), .req(reqData), .row, .noCcrEn,
		.isArX, .mask, .cmd);

	aluExecute aluExecute_i (.cmd, .ccrNow(ccr), .result, .flags);

	ccrUnit ccrUnit_i (.clk, .rst, .update(stageValid), .commit(cmd.commit),
		.finish(cmd.finish), .isArX(cmd.isArX), .noCcrEn(cmd.noCcrEn), .mask(cmd.mask),
		.flags, .ccr);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			stageValid <= 1'b0;
			ack        <= 1'b0;
			resultQ    <= '0;
		end else begin
			if (accept)
				busy <= 1'b1;
			else if (ack)
				busy <= 1'b0;   // Master drops or changes stb after this edge
			stageValid <= loadCmd;
			ack        <= stageValid;   // One cycle pulse
			if (stageValid & (|cmd.column))
				resultQ <= result;   // Column 0 keeps the last result
		end
	end

	assign respData.result = resultQ;
	assign respData.ccr    = ccr;

endmodule

/* tb/alu68k_checker.sv */
module alu68kChecker (
	input logic                clk,
	input logic                rst,
	input logic                cyc,
	input logic                stb,
	input logic                busy,
	input logic                ack,
	input alu68kPkg::aluResp_t respData
);

	logic accept;

	assign accept = cyc & stb & ~busy;   // Same accept as the slave

	ackInBusCycle: assert property (@(posedge clk) disable iff (rst) ack |-> (cyc && stb))
		else $error("ack outside a bus cycle");

	ackSinglePulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else $error("ack held for two cycles");

	// Accepting edge plus two, seen one edge later
	ackLatency: assert property (@(posedge clk) disable iff (rst) ack == $past(accept, 3))
		else $error("ack not two cycles after acceptance");

	respKnown: assert property (@(posedge clk) disable iff (rst) ack |-> !$isunknown(respData))
		else $error("respData has unknown bits during ack");

endmodule

bind alu68k alu68kChecker checker_i (
	.clk,
	.rst,
	.cyc,
	.stb,
	.busy,
	.ack,
	.respData
);

/* tb/alu68kTb.sv */
module alu68kTb;
	import alu68kPkg::*;

	localparam int clkPeriod   = 100;
	localparam int driveDelay  = 10;   // Inputs change this long after the rising edge
	localparam int resetCycles = 10;

	// One table entry with the command and its expected response
	typedef struct packed {
		aluReq_t req;
		word_t   result;
		ccr_t    ccr;
	} testVec_t;

	logic     clk = 1'b0;
	logic     rst;
	logic     cyc;
	logic     stb;
	aluReq_t  reqData;
	logic     ack;
	aluResp_t respData;

	testVec_t vecs[$];      // Stimulus table
	int       ackCount = 0;

	alu68k dut_i (
		.clk,
		.rst,
		.cyc,
		.stb,
		.reqData,
		.ack,
		.respData
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Acks as the master sees them
	always @(posedge clk) begin
		if (!rst && ack)
			ackCount <= ackCount + 1;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compareWord(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			failRun($sformatf("mismatch at time %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic compareCcr(input string name, input ccr_t got, input ccr_t exp);
		if (got !== exp)
			failRun($sformatf("mismatch at time %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic addVec(input opcode_t ird, input aluColumn_t column, input word_t aOp,
		input word_t dOp, input logic isByte, input logic [1:0] initFinish,
		input word_t expResult, input ccr_t expCcr);
		testVec_t v;
		v.req.ird      = ird;
		v.req.column   = column;
		v.req.aOperand = aOp;
		v.req.dOperand = dOp;
		v.req.isByte   = isByte;
		v.req.init     = initFinish[1];
		v.req.finish   = initFinish[0];
		v.result       = expResult;
		v.ccr          = expCcr;
		vecs.push_back(v);
	endtask

	// Columns are ird, column, a, d, byte, {init, finish}, result and ccr as X N Z V C
	task automatic buildTable;
		// Idle column right after reset commits nothing
		addVec(16'h0000, 3'd0, 16'h1234, 16'h5678, 1'b0, 2'b00, 16'h0000, 5'b00000);
		addVec(16'h3000, 3'd2, 16'h0001, 16'h7FFF, 1'b0, 2'b10, 16'h8000, 5'b01010); // MOVE
		addVec(16'hD040, 3'd2, 16'h3401, 16'h12FF, 1'b1, 2'b10, 16'h0000, 5'b10101); // ADD.B
		addVec(16'h9040, 3'd2, 16'h2000, 16'h1000, 1'b0, 2'b01, 16'hF000, 5'b11001); // SUB
		addVec(16'h0400, 3'd2, 16'h0001, 16'h0080, 1'b1, 2'b10, 16'h007F, 5'b00010); // SUBI.B
		// X and Z set, then ADDX with sticky Z
		addVec(16'hD040, 3'd2, 16'h0001, 16'hFFFF, 1'b0, 2'b10, 16'h0000, 5'b10101);
		addVec(16'hD140, 3'd2, 16'h0001, 16'hFFFE, 1'b0, 2'b01, 16'h0000, 5'b10101);
		addVec(16'hD140, 3'd2, 16'h0020, 16'h0010, 1'b0, 2'b01, 16'h0031, 5'b00000);
		addVec(16'hD140, 3'd2, 16'h0000, 16'h0000, 1'b0, 2'b01, 16'h0000, 5'b00000); // Z stays 0
		// Logic ops keep X
		addVec(16'h9040, 3'd2, 16'h0002, 16'h0001, 1'b0, 2'b10, 16'hFFFF, 5'b11001);
		addVec(16'h8040, 3'd2, 16'h00F0, 16'h0F0F, 1'b0, 2'b10, 16'h0FFF, 5'b10000); // OR
		addVec(16'hB140, 3'd2, 16'hAAAA, 16'hAAAA, 1'b0, 2'b10, 16'h0000, 5'b10100); // EOR
		addVec(16'hC040, 3'd1, 16'h8001, 16'hF00F, 1'b0, 2'b01, 16'h8001, 5'b11000); // AND
		addVec(16'hE050, 3'd1, 16'h0F00, 16'h00FF, 1'b0, 2'b10, 16'h0000, 5'b10101); // C from X
		// Single bit shifts
		addVec(16'hE148, 3'd4, 16'h8001, 16'h0000, 1'b0, 2'b01, 16'h0002, 5'b10001); // LSL
		addVec(16'hE058, 3'd4, 16'h0002, 16'h0000, 1'b0, 2'b01, 16'h0001, 5'b10000); // ROR
		addVec(16'hE008, 3'd4, 16'h1281, 16'h0000, 1'b1, 2'b01, 16'h1240, 5'b10001); // LSR.B
		addVec(16'hE050, 3'd4, 16'h0004, 16'h0000, 1'b0, 2'b01, 16'h8002, 5'b01000); // ROXR
		addVec(16'hE100, 3'd4, 16'h0040, 16'h0000, 1'b1, 2'b01, 16'h0080, 5'b01010); // ASL.B
		addVec(16'hE100, 3'd4, 16'h0001, 16'h0000, 1'b1, 2'b01, 16'h0002, 5'b00010); // V sticky
		addVec(16'hE040, 3'd4, 16'h8003, 16'h0000, 1'b0, 2'b01, 16'hC001, 5'b11001); // ASR
		addVec(16'hE110, 3'd4, 16'hAB80, 16'h0000, 1'b1, 2'b01, 16'hAB01, 5'b10001); // ROXL.B
		addVec(16'hE158, 3'd4, 16'h4000, 16'h0000, 1'b0, 2'b01, 16'h8000, 5'b11000); // ROL
		// ADDA leaves the ccr and column 0 leaves everything
		addVec(16'hD0C0, 3'd2, 16'h0234, 16'h1000, 1'b0, 2'b11, 16'h1234, 5'b11000);
		addVec(16'hD040, 3'd0, 16'hFFFF, 16'hFFFF, 1'b0, 2'b11, 16'h1234, 5'b11000);
		// BCD columns select no op, zero result and no flag change
		addVec(16'hC100, 3'd3, 16'h0001, 16'h0001, 1'b0, 2'b10, 16'h0000, 5'b11000); // ABCD
		addVec(16'h8100, 3'd3, 16'h1111, 16'h2222, 1'b0, 2'b10, 16'h0000, 5'b11000); // SBCD
	endtask

	task automatic runCommand(input int idx);
		testVec_t v;
		v       = vecs[idx];
		cyc     = 1'b1;
		stb     = 1'b1;   // Held high through the busy cycles
		reqData = v.req;
		do begin
			@(posedge clk);
			#driveDelay;
		end while (!ack);
		compareWord($sformatf("respData.result[%0d]", idx), respData.result, v.result);
		compareCcr($sformatf("respData.ccr[%0d]", idx), respData.ccr, v.ccr);
		@(posedge clk);   // Master samples ack here
		#driveDelay;
		if (ack)
			failRun($sformatf("ack for command %0d stayed high for a second cycle", idx));
	endtask

	initial begin
		rst     = 1'b1;
		cyc     = 1'b0;
		stb     = 1'b0;
		reqData = '0;
		buildTable();
		// Watchdog allows four cycles per command plus reset and slack
		fork
			begin
				#(clkPeriod * (vecs.size() * 4 + 20));
				failRun("timeout: the DUT did not answer every command in time");
			end
		join_none
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rst = 1'b0;
		for (int i = 0; i < vecs.size(); i++)
			runCommand(i);
		cyc = 1'b0;
		stb = 1'b0;
		repeat (3) @(posedge clk);
		#driveDelay;
		if (ackCount == vecs.size()) begin
			$display("All tests passed");
			$finish;
		end else begin
			failRun($sformatf("sent %0d commands but counted %0d acks", vecs.size(), ackCount));
		end
	end

endmodule

/* all.f */
common/alu68kPkg.sv
decode/rowDecoder.sv
decode/ccrMaskTable.sv
decode/aluOpSelect.sv
execute/aluExecute.sv
logic/ccrUnit.sv
logic/alu68k.sv
tb/alu68k_checker.sv
tb/alu68kTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module alu68kTb -f all.f -o alu68kSim > sim.log 2>&1 \
	&& ./obj_dir/alu68kSim >> sim.log 2>&1 \
	|| echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
